/* Bender.yml */
package:
  name: vending_machine

sources:
  - hdl/vend_pkg.sv
  - hdl/key_decode.sv
  - hdl/vend_core.sv
  - hdl/status_hold.sv
  - hdl/vending_machine.sv
  - target: test
    files:
      - test/tb_vending_machine.sv

/* hdl/key_decode.sv */
`timescale 1ns/1ps

module key_decode (
    input  logic              clk,
    input  logic              rst,
    input  vend_pkg::buttons_t buttons,
    output vend_pkg::cmd_t     cmd
);
    import vend_pkg::*;

    cmd_t   cmd_nxt;
    money_t coin_val;
    logic   coin_hit;

    // coin group counts only when exactly one coin is pressed
    always_comb begin
        coin_hit = 1'b1;
        coin_val = '0;
        case ({buttons[BTN_COIN_LARGE], buttons[BTN_COIN_MID], buttons[BTN_COIN_SMALL]})
            3'b100:  coin_val = COIN_LARGE;
            3'b010:  coin_val = COIN_MID;
            3'b001:  coin_val = COIN_SMALL;
            default: coin_hit = 1'b0;
        endcase
    end

    // fixed priority, highest first
    always_comb begin
        cmd_nxt.valid = 1'b1;
        cmd_nxt.op    = OP_NONE;
        cmd_nxt.coin  = coin_val;
        if (buttons[BTN_UP])
            cmd_nxt.op = OP_UP;
        else if (buttons[BTN_DOWN])
            cmd_nxt.op = OP_DOWN;
        else if (buttons[BTN_SELECT])
            cmd_nxt.op = OP_SELECT;
        else if (coin_hit)
            cmd_nxt.op = OP_COIN;
        else if (buttons[BTN_BUY])
            cmd_nxt.op = OP_BUY;
        else if (buttons[BTN_RETURN])
            cmd_nxt.op = OP_REFUND;
        else if (buttons[BTN_RESTOCK])
            cmd_nxt.op = OP_RESTOCK;
        else if (buttons[BTN_ADMIN])
            cmd_nxt.op = OP_ADMIN;
        else
            cmd_nxt.valid = 1'b0;
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            cmd <= '0;
        end else begin
            cmd <= cmd_nxt;
        end
    end

endmodule

/* hdl/status_hold.sv */
`timescale 1ns/1ps

module status_hold (
    input  logic                clk,
    input  logic                rst,
    input  vend_pkg::vend_evt_t evt,
    output vend_pkg::msg_e      msg,
    output vend_pkg::slot_t     msg_slot
);
    import vend_pkg::*;

    hold_t hold_cnt;

    //////////////////////////////
    // message hold timer
    //////////////////////////////

    // a new event restarts the hold
    always_ff @(posedge clk) begin
        if (!rst) begin
            msg      <= MSG_NONE;
            hold_cnt <= '0;
        end else if (evt.valid) begin
            msg      <= evt.msg;
            hold_cnt <= hold_t'(MSG_HOLD - 1);
        end else if (msg != MSG_NONE) begin
            if (hold_cnt == '0)
                msg <= MSG_NONE;
            else
                hold_cnt <= hold_cnt - 1'b1;
        end
    end

    // slot the message refers to
    always_ff @(posedge clk) begin
        if (evt.valid)
            msg_slot <= evt.slot;
    end

endmodule

/* hdl/vend_core.sv */
`timescale 1ns/1ps

module vend_core (
    input  logic                clk,
    input  logic                rst,
    input  vend_pkg::cmd_t      cmd,
    output vend_pkg::money_t    credit,
    output vend_pkg::slot_t     cursor,
    output vend_pkg::slot_t     selected,
    output logic                selected_valid,
    output vend_pkg::count_t    stock_shown,
    output logic                admin,
    output vend_pkg::money_t    refund,
    output logic                refund_valid,
    output vend_pkg::vend_evt_t evt
);
    import vend_pkg::*;

    count_t    stock [NUM_SLOTS];
    count_t    stock_nxt [NUM_SLOTS];
    money_t    credit_nxt;
    slot_t     cursor_nxt;
    slot_t     sel_nxt;
    logic      sel_valid_nxt;
    logic      admin_nxt;
    logic      refund_valid_nxt;
    vend_evt_t evt_nxt;
    logic [8:0] credit_sum;

    // 9 bit sum so the carry shows saturation
    assign credit_sum = {1'b0, credit} + {1'b0, cmd.coin};

    //////////////////////////////
    // command execution
    //////////////////////////////

    always_comb begin
        stock_nxt        = stock;
        credit_nxt       = credit;
        cursor_nxt       = cursor;
        sel_nxt          = selected;
        sel_valid_nxt    = selected_valid;
        admin_nxt        = admin;
        refund_valid_nxt = 1'b0;
        evt_nxt          = '0;

        if (cmd.valid) begin
            case (cmd.op)
                OP_UP: begin
                    if (cursor != '0)
                        cursor_nxt = cursor - 2'd1;
                end
                OP_DOWN: begin
                    if (cursor != slot_t'(NUM_SLOTS - 1))
                        cursor_nxt = cursor + 2'd1;
                end
                OP_SELECT: begin
                    // same slot again unselects it
                    if (selected_valid && selected == cursor) begin
                        sel_valid_nxt = 1'b0;
                    end else if (stock[cursor] != '0) begin
                        sel_nxt       = cursor;
                        sel_valid_nxt = 1'b1;
                    end
                end
                OP_COIN: begin
                    credit_nxt = credit_sum[8] ? CREDIT_MAX : credit_sum[7:0];
                end
                OP_BUY: begin
                    if (selected_valid) begin
                        if (credit >= PRICE[selected] && stock[selected] != '0) begin
                            stock_nxt[selected] = stock[selected] - 4'd1;
                            credit_nxt          = credit - PRICE[selected];
                            evt_nxt.valid       = 1'b1;
                            evt_nxt.msg         = MSG_THANKS;
                            evt_nxt.slot        = selected;
                        end else if (credit < PRICE[selected]) begin
                            evt_nxt.valid = 1'b1;
                            evt_nxt.msg   = MSG_NO_MONEY;
                            evt_nxt.slot  = selected;
                        end
                        sel_valid_nxt = 1'b0;
                    end
                end
                OP_REFUND: begin
                    // whole credit goes back in one strobe
                    refund_valid_nxt = 1'b1;
                    credit_nxt       = '0;
                end
                OP_RESTOCK: begin
                    if (admin && stock[cursor] < STOCK_MAX)
                        stock_nxt[cursor] = stock[cursor] + 4'd1;
                end
                OP_ADMIN: begin
                    admin_nxt = ~admin;
                    if (!admin) begin
                        evt_nxt.valid = 1'b1;
                        evt_nxt.msg   = MSG_ADMIN;
                        evt_nxt.slot  = cursor;
                    end
                end
                default: ;
            endcase
        end
    end

    //////////////////////////////
    // state registers
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            stock          <= STOCK_INIT;
            credit         <= '0;
            cursor         <= '0;
            selected       <= '0;
            selected_valid <= 1'b0;
            admin          <= 1'b0;
            refund_valid   <= 1'b0;
            evt            <= '0;
            stock_shown    <= STOCK_INIT[0];
        end else begin
            stock          <= stock_nxt;
            credit         <= credit_nxt;
            cursor         <= cursor_nxt;
            selected       <= sel_nxt;
            selected_valid <= sel_valid_nxt;
            admin          <= admin_nxt;
            refund_valid   <= refund_valid_nxt;
            evt            <= evt_nxt;
            // view follows the cursor after this command
            stock_shown    <= stock_nxt[cursor_nxt];
        end
    end

    // refund amount is read only with refund_valid
    always_ff @(posedge clk) begin
        if (cmd.valid && cmd.op == OP_REFUND)
            refund <= credit;
    end

endmodule

/* hdl/vend_pkg.sv */
package vend_pkg;

    ////////////////////////////////
    // machine sizes
    ////////////////////////////////

    localparam int NUM_SLOTS = 4;
    localparam int MSG_HOLD  = 16;

    // one-shot strobes from the button front end
    typedef logic [11:0] buttons_t;

    // amounts in 100 won units
    typedef logic [7:0] money_t;

    typedef logic [3:0] count_t;
    typedef logic [1:0] slot_t;

    // down counter for the message display time
    typedef logic [$clog2(MSG_HOLD)-1:0] hold_t;

    localparam count_t STOCK_MAX  = 4'd9;
    localparam money_t CREDIT_MAX = 8'd255;

    // per slot tables indexed by slot
    localparam money_t PRICE [NUM_SLOTS] = '{8'd10, 8'd12, 8'd15, 8'd18};
    localparam count_t STOCK_INIT [NUM_SLOTS] = '{4'd9, 4'd1, 4'd0, 4'd4};

    localparam money_t COIN_SMALL = 8'd1;
    localparam money_t COIN_MID   = 8'd5;
    localparam money_t COIN_LARGE = 8'd10;

    ////////////////////////////////
    // button bit positions
    ////////////////////////////////

    localparam int BTN_COIN_LARGE = 0;
    localparam int BTN_COIN_MID   = 1;
    localparam int BTN_COIN_SMALL = 2;
    localparam int BTN_RETURN     = 3;
    localparam int BTN_DOWN       = 4;
    localparam int BTN_RESTOCK    = 5;
    localparam int BTN_SELECT     = 7;
    localparam int BTN_BUY        = 9;
    localparam int BTN_UP         = 10;
    localparam int BTN_ADMIN      = 11;

    ////////////////////////////////
    // commands and messages
    ////////////////////////////////

    typedef enum logic [3:0] {
        OP_NONE,
        OP_UP,
        OP_DOWN,
        OP_SELECT,
        OP_COIN,
        OP_BUY,
        OP_REFUND,
        OP_RESTOCK,
        OP_ADMIN
    } op_e;

    typedef enum logic [1:0] {
        MSG_NONE,
        MSG_NO_MONEY,
        MSG_THANKS,
        MSG_ADMIN
    } msg_e;

    // decoded command with coin used only by OP_COIN
    typedef struct packed {
        logic   valid;
        op_e    op;
        money_t coin;
    } cmd_t;

    // message request toward the status stage
    typedef struct packed {
        logic  valid;
        msg_e  msg;
        slot_t slot;
    } vend_evt_t;

endpackage

/* hdl/vending_machine.sv */
`timescale 1ns/1ps

module vending_machine (
    input  logic               clk,
    input  logic               rst,
    input  vend_pkg::buttons_t buttons,
    output vend_pkg::money_t   credit,
    output vend_pkg::slot_t    cursor,
    output vend_pkg::slot_t    selected,
    output logic               selected_valid,
    output vend_pkg::count_t   stock_shown,
    output logic               admin,
    output vend_pkg::money_t   refund,
    output logic               refund_valid,
    output vend_pkg::msg_e     msg,
    output vend_pkg::slot_t    msg_slot
);
    import vend_pkg::*;

    cmd_t      cmd;
    vend_evt_t evt;

    // stage 1 buttons to command
    key_decode key_decode_i (
        .clk     (clk),
        .rst     (rst),
        .buttons (buttons),
        .cmd     (cmd)
    );

    // stage 2 machine state
    vend_core vend_core_i (
        .clk            (clk),
        .rst            (rst),
        .cmd            (cmd),
        .credit         (credit),
        .cursor         (cursor),
        .selected       (selected),
        .selected_valid (selected_valid),
        .stock_shown    (stock_shown),
        .admin          (admin),
        .refund         (refund),
        .refund_valid   (refund_valid),
        .evt            (evt)
    );

    // stage 3 message display
    status_hold status_hold_i (
        .clk      (clk),
        .rst      (rst),
        .evt      (evt),
        .msg      (msg),
        .msg_slot (msg_slot)
    );

endmodule

/* test/tb_vending_machine.sv */
`timescale 1ns/1ps

module tb_vending_machine;
    import vend_pkg::*;

    // one table row with strobe, expected outputs and idle cycles after the check
    typedef struct packed {
        buttons_t   btn;
        money_t     credit;
        count_t     stock;
        slot_t      cursor;
        logic       sel_valid;
        logic       admin;
        msg_e       msg;
        slot_t      msg_slot;
        logic       refund_valid;
        money_t     refund;
        logic [7:0] idle;
    } row_t;

    logic     clk;
    logic     rst;
    buttons_t buttons;
    money_t   credit;
    slot_t    cursor;
    slot_t    selected;
    logic     selected_valid;
    count_t   stock_shown;
    logic     admin;
    money_t   refund;
    logic     refund_valid;
    msg_e     msg;
    slot_t    msg_slot;

    row_t rows[$];
    int   errors;
    int   row_idx;
    int   cycles;
    int   limit;

    vending_machine vending_machine_i (
        .clk            (clk),
        .rst            (rst),
        .buttons        (buttons),
        .credit         (credit),
        .cursor         (cursor),
        .selected       (selected),
        .selected_valid (selected_valid),
        .stock_shown    (stock_shown),
        .admin          (admin),
        .refund         (refund),
        .refund_valid   (refund_valid),
        .msg            (msg),
        .msg_slot       (msg_slot)
    );

    always #5 clk = ~clk;

    // run limit is set once the table is known
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout: the test did not finish within %0d cycles", limit);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    //////////////////////////////
    // compare tasks
    //////////////////////////////

    task automatic check_money(input string name, input money_t got, input money_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED row %0d: %s = 0x%0h, expected 0x%0h", row_idx, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input count_t got, input count_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED row %0d: %s = 0x%0h, expected 0x%0h", row_idx, name, got, exp);
        end
    endtask

    task automatic check_slot(input string name, input slot_t got, input slot_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED row %0d: %s = 0x%0h, expected 0x%0h", row_idx, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED row %0d: %s = 0x%0h, expected 0x%0h", row_idx, name, got, exp);
        end
    endtask

    task automatic check_msg(input string name, input msg_e got, input msg_e exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED row %0d: %s = 0x%0h, expected 0x%0h", row_idx, name, got, exp);
        end
    endtask

    //////////////////////////////
    // stimulus table
    //////////////////////////////

    function automatic buttons_t press(input int bit_pos);
        buttons_t b;
        b = '0;
        b[bit_pos] = 1'b1;
        return b;
    endfunction

    task automatic add_row(input buttons_t btn, input money_t cr, input count_t st,
                           input slot_t cur, input logic sel, input logic adm,
                           input msg_e m, input slot_t ms, input logic rv,
                           input money_t rf, input int idle);
        row_t r;
        r.btn          = btn;
        r.credit       = cr;
        r.stock        = st;
        r.cursor       = cur;
        r.sel_valid    = sel;
        r.admin        = adm;
        r.msg          = m;
        r.msg_slot     = ms;
        r.refund_valid = rv;
        r.refund       = rf;
        r.idle         = 8'(idle);
        rows.push_back(r);
    endtask

    task automatic build_table();
        int k;
        int val;
        // coins then an ignored two coin press
        add_row(press(BTN_COIN_SMALL), 1, 9, 0, 0, 0, MSG_NONE, 0, 0, 0, 0);
        add_row(press(BTN_COIN_MID), 6, 9, 0, 0, 0, MSG_NONE, 0, 0, 0, 0);
        add_row(press(BTN_COIN_LARGE), 16, 9, 0, 0, 0, MSG_NONE, 0, 0, 0, 0);
        add_row(press(BTN_COIN_SMALL) | press(BTN_COIN_MID), 16, 9, 0, 0, 0, MSG_NONE, 0, 0, 0, 0);
        // cursor walk stops at slot 3
        add_row(press(BTN_DOWN), 16, 1, 1, 0, 0, MSG_NONE, 0, 0, 0, 0);
        add_row(press(BTN_DOWN), 16, 0, 2, 0, 0, MSG_NONE, 0, 0, 0, 0);
        add_row(press(BTN_DOWN), 16, 4, 3, 0, 0, MSG_NONE, 0, 0, 0, 0);
        add_row(press(BTN_DOWN), 16, 4, 3, 0, 0, MSG_NONE, 0, 0, 0, 0);
        add_row(press(BTN_UP), 16, 0, 2, 0, 0, MSG_NONE, 0, 0, 0, 0);
        add_row(press(BTN_UP), 16, 1, 1, 0, 0, MSG_NONE, 0, 0, 0, 0);
        add_row(press(BTN_UP), 16, 9, 0, 0, 0, MSG_NONE, 0, 0, 0, 0);
        // empty slot 2 cannot be selected
        add_row(press(BTN_DOWN), 16, 1, 1, 0, 0, MSG_NONE, 0, 0, 0, 0);
        add_row(press(BTN_DOWN), 16, 0, 2, 0, 0, MSG_NONE, 0, 0, 0, 0);
        add_row(press(BTN_SELECT), 16, 0, 2, 0, 0, MSG_NONE, 0, 0, 0, 0);
        add_row(press(BTN_UP), 16, 1, 1, 0, 0, MSG_NONE, 0, 0, 0, 0);
        add_row(press(BTN_UP), 16, 9, 0, 0, 0, MSG_NONE, 0, 0, 0, 0);
        add_row(press(BTN_SELECT), 16, 9, 0, 1, 0, MSG_NONE, 0, 0, 0, 0);
        add_row(press(BTN_SELECT), 16, 9, 0, 0, 0, MSG_NONE, 0, 0, 0, 0);
        // refused sale on slot 3 and message expiry
        add_row(press(BTN_DOWN), 16, 1, 1, 0, 0, MSG_NONE, 0, 0, 0, 0);
        add_row(press(BTN_DOWN), 16, 0, 2, 0, 0, MSG_NONE, 0, 0, 0, 0);
        add_row(press(BTN_DOWN), 16, 4, 3, 0, 0, MSG_NONE, 0, 0, 0, 0);
        add_row(press(BTN_SELECT), 16, 4, 3, 1, 0, MSG_NONE, 0, 0, 0, 0);
        add_row(press(BTN_BUY), 16, 4, 3, 0, 0, MSG_NO_MONEY, 3, 0, 0, MSG_HOLD);
        add_row('0, 16, 4, 3, 0, 0, MSG_NONE, 0, 0, 0, 0);
        // sale on slot 0
        add_row(press(BTN_UP), 16, 0, 2, 0, 0, MSG_NONE, 0, 0, 0, 0);
        add_row(press(BTN_UP), 16, 1, 1, 0, 0, MSG_NONE, 0, 0, 0, 0);
        add_row(press(BTN_UP), 16, 9, 0, 0, 0, MSG_NONE, 0, 0, 0, 0);
        add_row(press(BTN_SELECT), 16, 9, 0, 1, 0, MSG_NONE, 0, 0, 0, 0);
        add_row(press(BTN_BUY), 6, 8, 0, 0, 0, MSG_THANKS, 0, 0, 0, MSG_HOLD);
        // refund of the rest
        add_row(press(BTN_RETURN), 0, 8, 0, 0, 0, MSG_NONE, 0, 1, 6, 0);
        // admin mode and restock of slot 1 up to the ceiling
        add_row(press(BTN_ADMIN), 0, 8, 0, 0, 1, MSG_ADMIN, 0, 0, 0, MSG_HOLD);
        add_row(press(BTN_DOWN), 0, 1, 1, 0, 1, MSG_NONE, 0, 0, 0, 0);
        for (k = 2; k <= 10; k++) begin
            val = (k > 9) ? 9 : k;
            add_row(press(BTN_RESTOCK), 0, val, 1, 0, 1, MSG_NONE, 0, 0, 0, 0);
        end
        add_row(press(BTN_ADMIN), 0, 9, 1, 0, 0, MSG_NONE, 0, 0, 0, 0);
        add_row(press(BTN_DOWN), 0, 0, 2, 0, 0, MSG_NONE, 0, 0, 0, 0);
        add_row(press(BTN_DOWN), 0, 4, 3, 0, 0, MSG_NONE, 0, 0, 0, 0);
        add_row(press(BTN_RESTOCK), 0, 4, 3, 0, 0, MSG_NONE, 0, 0, 0, 0);
        // credit saturation
        for (k = 1; k <= 26; k++) begin
            val = (k * 10 > 255) ? 255 : k * 10;
            add_row(press(BTN_COIN_LARGE), val, 4, 3, 0, 0, MSG_NONE, 0, 0, 0, 0);
        end
        add_row(press(BTN_RETURN), 0, 4, 3, 0, 0, MSG_NONE, 0, 1, 255, 0);
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        clk     = 1'b0;
        rst     = 1'b0;
        buttons = '0;
        errors  = 0;
        row_idx = 0;
        cycles  = 0;
        limit   = 0;

        build_table();
        limit = rows.size() * (MSG_HOLD + 8) + 100;

        repeat (2) @(posedge clk);
        rst <= 1'b1;

        for (row_idx = 0; row_idx < rows.size(); row_idx++) begin
            @(posedge clk);
            buttons <= rows[row_idx].btn;
            @(posedge clk);
            buttons <= '0;
            // core outputs settle after the second edge
            @(posedge clk);
            @(negedge clk);
            check_flag("refund_valid", refund_valid, rows[row_idx].refund_valid);
            if (rows[row_idx].refund_valid)
                check_money("refund", refund, rows[row_idx].refund);
            // message stage one edge later
            @(posedge clk);
            @(negedge clk);
            check_money("credit", credit, rows[row_idx].credit);
            check_count("stock_shown", stock_shown, rows[row_idx].stock);
            check_slot("cursor", cursor, rows[row_idx].cursor);
            check_flag("selected_valid", selected_valid, rows[row_idx].sel_valid);
            // every selection in the table is made at the cursor slot
            if (rows[row_idx].sel_valid)
                check_slot("selected", selected, rows[row_idx].cursor);
            check_flag("admin", admin, rows[row_idx].admin);
            check_msg("msg", msg, rows[row_idx].msg);
            if (rows[row_idx].msg != MSG_NONE)
                check_slot("msg_slot", msg_slot, rows[row_idx].msg_slot);
            repeat (int'(rows[row_idx].idle)) @(posedge clk);
        end

        $display("rows run: %0d, errors: %0d", rows.size(), errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* vending_machine.f */
hdl/vend_pkg.sv
hdl/key_decode.sv
hdl/vend_core.sv
hdl/status_hold.sv
hdl/vending_machine.sv
test/tb_vending_machine.sv
